//--- bp_predictor.f
source/bp_pkg.sv
source/bp_update_decode.sv
source/bp_target_buffer.sv
source/bp_direction_table.sv
source/bp_return_stack.sv
source/bp_fetch_pc.sv
source/bp_predictor.sv
verification/bp_clock_gen.sv
verification/bp_predictor_tb.sv

//--- source/bp_direction_table.sv
`timescale 1ns/1ns

module bp_direction_table #(
    parameter int BTB_INDEX_W = 7,
    parameter int HISTORY_W   = 5,
    parameter int PHT_PC_W    = 7
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [31:0]                   rd_pc_i,
    input  logic [31:0]                   cur_pc_i,
    input  logic [1:0]                    wr_en_i,
    input  logic [BTB_INDEX_W-1:0]        wr_index_i,
    input  logic [HISTORY_W-1:0]          wr_history_i,
    input  logic [HISTORY_W+PHT_PC_W-1:0] wr_pht_index_i,
    input  logic [1:0]                    wr_scnt_i,
    output logic [HISTORY_W-1:0]          history_o [2],
    output logic [1:0]                    scnt_o [2],
    output logic                          init_done_o
);

    localparam int PHT_IDX_W = HISTORY_W + PHT_PC_W;

    typedef enum logic {
        ST_SWEEP,
        ST_READY
    } init_state_e;

    init_state_e            state;
    logic [PHT_IDX_W-1:0]   sweep_cnt;
    logic [31:0]            rd_hash;
    logic [BTB_INDEX_W-1:0] rd_index_q;
    logic [1:0]             we;
    logic [BTB_INDEX_W-1:0] bht_waddr;
    logic [HISTORY_W-1:0]   bht_wdata;
    logic [PHT_IDX_W-1:0]   pht_waddr;
    logic [1:0]             pht_wdata;

    assign init_done_o = (state == ST_READY);

    // one entry per cycle over the whole PHT
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_SWEEP;
            sweep_cnt <= '0;
        end else if (state == ST_SWEEP) begin
            sweep_cnt <= sweep_cnt + 1'b1;
            if (&sweep_cnt) begin
                state <= ST_READY;
            end
        end
    end

    // the sweep owns the write port until done
    assign we        = init_done_o ? wr_en_i : 2'b11;
    assign bht_waddr = init_done_o ? wr_index_i : sweep_cnt[BTB_INDEX_W-1:0];
    assign bht_wdata = init_done_o ? wr_history_i : '0;
    assign pht_waddr = init_done_o ? wr_pht_index_i : sweep_cnt;
    assign pht_wdata = init_done_o ? wr_scnt_i : 2'b01;  // weakly not-taken

    assign rd_hash = bp_pkg::btb_hash(rd_pc_i);

    always_ff @(posedge clk) begin
        rd_index_q <= rd_hash[BTB_INDEX_W-1:0];
    end

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic [HISTORY_W-1:0] bht [2**BTB_INDEX_W];
        logic [1:0]           pht [2**PHT_IDX_W];

        always_ff @(posedge clk) begin
            if (we[b]) begin
                bht[bht_waddr] <= bht_wdata;
                pht[pht_waddr] <= pht_wdata;
            end
        end

        assign history_o[b] = bht[rd_index_q];
        assign scnt_o[b]    = pht[{history_o[b], cur_pc_i[PHT_PC_W+2:3]}];  // local pattern
    end

    // back end holds its corrections until the tables are initialised
    assert property (@(posedge clk) disable iff (rst) (|wr_en_i) |-> init_done_o)
        else $error("table update during init sweep");

endmodule

//--- source/bp_fetch_pc.sv
`timescale 1ns/1ns

module bp_fetch_pc #(
    parameter int HISTORY_W = 5
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush_i,
    input  logic [31:0]          redirect_i,
    input  logic                 fetch_ready_i,
    input  logic                 init_done_i,
    input  logic [1:0]           btb_hit_i,
    input  bp_pkg::br_type_e     btb_type_i [2],
    input  logic [31:0]          btb_target_i [2],
    input  logic [1:0]           btb_is_uncond_i,
    input  logic [HISTORY_W-1:0] dir_history_i [2],
    input  logic [1:0]           dir_scnt_i [2],
    input  logic [31:0]          ras_top_i,
    output logic [31:0]          pc_next_o,
    output logic                 push_o,
    output logic                 pop_o,
    output logic [31:0]          push_addr_o,
    output logic                 fetch_valid_o,
    output logic [31:0]          pc_o,
    output logic [1:0]           mask_o,
    output logic [1:0]           taken_o,
    output logic [31:0]          target_o [2],
    output logic [31:0]          next_pc_o [2],
    output logic [HISTORY_W-1:0] history_o [2],
    output logic [1:0]           scnt_o [2],
    output logic [1:0]           hit_o
);

    logic        accept;
    logic [1:0]  taken;
    logic [1:0]  is_call;
    logic [1:0]  is_ret;
    logic [31:0] slot1_pc;
    logic [31:0] pair_next;

    assign accept    = fetch_valid_o && fetch_ready_i;
    assign slot1_pc  = {pc_o[31:3], 3'b100};
    assign pair_next = {pc_o[31:3] + 29'd1, 3'b000};

    for (genvar i = 0; i < 2; i++) begin : g_slot
        assign taken[i]    = btb_hit_i[i] && (btb_is_uncond_i[i] || dir_scnt_i[i][1]);
        assign is_call[i]  = btb_hit_i[i] && mask_o[i] && (btb_type_i[i] == bp_pkg::BR_CALL);
        assign is_ret[i]   = btb_hit_i[i] && mask_o[i] && (btb_type_i[i] == bp_pkg::BR_RETURN);
        assign target_o[i] = (btb_type_i[i] == bp_pkg::BR_RETURN) ? ras_top_i : btb_target_i[i];
        assign taken_o[i]  = taken[i] && mask_o[i];

        assign history_o[i] = dir_history_i[i];
        assign scnt_o[i]    = dir_scnt_i[i];
    end

    assign hit_o = btb_hit_i;

    // slot 1 is cut off by a taken slot 0
    assign mask_o = {pc_o[2] || !taken[0], !pc_o[2]};

    assign next_pc_o[0] = taken[0] ? target_o[0] : slot1_pc;
    assign next_pc_o[1] = taken[1] ? target_o[1] : pair_next;

    always_comb begin
        if (rst || !init_done_i) begin
            pc_next_o = bp_pkg::INIT_PC;
        end else if (flush_i) begin
            pc_next_o = redirect_i;
        end else if (!accept) begin
            pc_next_o = pc_o;  // fetch stalled
        end else if (taken[0] && !pc_o[2]) begin
            pc_next_o = target_o[0];
        end else if (taken[1]) begin
            pc_next_o = target_o[1];
        end else begin
            pc_next_o = pair_next;
        end
    end

    // stack moves only for a pair that fetch really takes
    assign push_o      = accept && !flush_i && (|is_call);
    assign pop_o       = accept && !flush_i && (|is_ret);
    assign push_addr_o = is_call[0] ? slot1_pc : pair_next;

    always_ff @(posedge clk) begin
        pc_o <= pc_next_o;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_valid_o <= 1'b0;
        end else begin
            fetch_valid_o <= init_done_i;
        end
    end

endmodule

//--- source/bp_pkg.sv
package bp_pkg;

    // branch kind as recorded in the BTB
    typedef enum logic [1:0] {
        BR_NORMAL = 2'b00,  // conditional
        BR_CALL   = 2'b01,
        BR_RETURN = 2'b10,
        BR_JUMP   = 2'b11
    } br_type_e;

    localparam logic [31:0] INIT_PC = 32'h1c00_0000;

    // defaults handed down by the top level
    localparam int DEF_BTB_INDEX_W = 7;
    localparam int DEF_HISTORY_W   = 5;
    localparam int DEF_PHT_PC_W    = 7;
    localparam int DEF_RAS_DEPTH   = 8;

    localparam int TAG_W = 8;  // pc bits from 12 up

    // callers keep the low BTB_INDEX_W bits
    function automatic logic [31:0] btb_hash(input logic [31:0] pc);
        return (pc >> 9) ^ (pc >> 3);
    endfunction

    function automatic logic [TAG_W-1:0] get_tag(input logic [31:0] pc);
        return pc[12 +: TAG_W];
    endfunction

endpackage

//--- source/bp_predictor.sv
`timescale 1ns/1ns

module bp_predictor #(
    parameter int BTB_INDEX_W = bp_pkg::DEF_BTB_INDEX_W,
    parameter int HISTORY_W   = bp_pkg::DEF_HISTORY_W,
    parameter int PHT_PC_W    = bp_pkg::DEF_PHT_PC_W,
    parameter int RAS_DEPTH   = bp_pkg::DEF_RAS_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush_i,
    input  logic [31:0]          redirect_i,
    input  logic [1:0]           upd_valid_i,
    input  logic [31:0]          upd_pc_i [2],
    input  logic [31:0]          upd_target_i [2],
    input  bp_pkg::br_type_e     upd_type_i [2],
    input  logic [1:0]           upd_is_branch_i,
    input  logic [1:0]           upd_taken_i,
    input  logic [HISTORY_W-1:0] upd_history_i [2],
    input  logic [1:0]           upd_scnt_i [2],
    input  logic [1:0]           upd_type_miss_i,
    input  logic                 fetch_ready_i,
    output logic                 fetch_valid_o,
    output logic [31:0]          pc_o,
    output logic [1:0]           mask_o,
    output logic [1:0]           taken_o,
    output logic [31:0]          target_o [2],
    output logic [31:0]          next_pc_o [2],
    output logic [HISTORY_W-1:0] history_o [2],
    output logic [1:0]           scnt_o [2],
    output logic [1:0]           hit_o
);

    logic [1:0]                    wr_en;
    logic [BTB_INDEX_W-1:0]        wr_index;
    logic [bp_pkg::TAG_W-1:0]      wr_tag;
    logic [31:0]                   wr_target;
    bp_pkg::br_type_e              wr_type;
    logic                          wr_is_branch;
    logic                          wr_is_uncond;
    logic [HISTORY_W-1:0]          wr_history;
    logic [HISTORY_W+PHT_PC_W-1:0] wr_pht_index;
    logic [1:0]                    wr_scnt;
    logic [31:0]                   pc_next;
    logic [1:0]                    btb_hit;
    bp_pkg::br_type_e              btb_type [2];
    logic [31:0]                   btb_target [2];
    logic [1:0]                    btb_is_uncond;
    logic [HISTORY_W-1:0]          dir_history [2];
    logic [1:0]                    dir_scnt [2];
    logic                          init_done;
    logic                          push;
    logic                          pop;
    logic [31:0]                   push_addr;
    logic [31:0]                   ras_top;

    bp_update_decode #(
        .BTB_INDEX_W(BTB_INDEX_W),
        .HISTORY_W  (HISTORY_W),
        .PHT_PC_W   (PHT_PC_W)
    ) update_decode_i (
        .clk            (clk),
        .upd_valid_i    (upd_valid_i),
        .upd_pc_i       (upd_pc_i),
        .upd_target_i   (upd_target_i),
        .upd_type_i     (upd_type_i),
        .upd_is_branch_i(upd_is_branch_i),
        .upd_taken_i    (upd_taken_i),
        .upd_history_i  (upd_history_i),
        .upd_scnt_i     (upd_scnt_i),
        .upd_type_miss_i(upd_type_miss_i),
        .wr_en_o        (wr_en),
        .wr_index_o     (wr_index),
        .wr_tag_o       (wr_tag),
        .wr_target_o    (wr_target),
        .wr_type_o      (wr_type),
        .wr_is_branch_o (wr_is_branch),
        .wr_is_uncond_o (wr_is_uncond),
        .wr_history_o   (wr_history),
        .wr_pht_index_o (wr_pht_index),
        .wr_scnt_o      (wr_scnt)
    );

    bp_target_buffer #(
        .BTB_INDEX_W(BTB_INDEX_W)
    ) target_buffer_i (
        .clk           (clk),
        .rst           (rst),
        .rd_pc_i       (pc_next),
        .cur_pc_i      (pc_o),
        .wr_en_i       (wr_en),
        .wr_index_i    (wr_index),
        .wr_tag_i      (wr_tag),
        .wr_target_i   (wr_target),
        .wr_type_i     (wr_type),
        .wr_is_branch_i(wr_is_branch),
        .wr_is_uncond_i(wr_is_uncond),
        .hit_o         (btb_hit),
        .type_o        (btb_type),
        .target_o      (btb_target),
        .is_uncond_o   (btb_is_uncond)
    );

    bp_direction_table #(
        .BTB_INDEX_W(BTB_INDEX_W),
        .HISTORY_W  (HISTORY_W),
        .PHT_PC_W   (PHT_PC_W)
    ) direction_table_i (
        .clk           (clk),
        .rst           (rst),
        .rd_pc_i       (pc_next),
        .cur_pc_i      (pc_o),
        .wr_en_i       (wr_en),
        .wr_index_i    (wr_index),
        .wr_history_i  (wr_history),
        .wr_pht_index_i(wr_pht_index),
        .wr_scnt_i     (wr_scnt),
        .history_o     (dir_history),
        .scnt_o        (dir_scnt),
        .init_done_o   (init_done)
    );

    bp_return_stack #(
        .RAS_DEPTH(RAS_DEPTH)
    ) return_stack_i (
        .clk        (clk),
        .rst        (rst),
        .push_i     (push),
        .pop_i      (pop),
        .push_addr_i(push_addr),
        .top_o      (ras_top)
    );

    bp_fetch_pc #(
        .HISTORY_W(HISTORY_W)
    ) fetch_pc_i (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (flush_i),
        .redirect_i     (redirect_i),
        .fetch_ready_i  (fetch_ready_i),
        .init_done_i    (init_done),
        .btb_hit_i      (btb_hit),
        .btb_type_i     (btb_type),
        .btb_target_i   (btb_target),
        .btb_is_uncond_i(btb_is_uncond),
        .dir_history_i  (dir_history),
        .dir_scnt_i     (dir_scnt),
        .ras_top_i      (ras_top),
        .pc_next_o      (pc_next),
        .push_o         (push),
        .pop_o          (pop),
        .push_addr_o    (push_addr),
        .fetch_valid_o  (fetch_valid_o),
        .pc_o           (pc_o),
        .mask_o         (mask_o),
        .taken_o        (taken_o),
        .target_o       (target_o),
        .next_pc_o      (next_pc_o),
        .history_o      (history_o),
        .scnt_o         (scnt_o),
        .hit_o          (hit_o)
    );

endmodule

//--- source/bp_return_stack.sv
`timescale 1ns/1ns

module bp_return_stack #(
    parameter int RAS_DEPTH = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        push_i,
    input  logic        pop_i,
    input  logic [31:0] push_addr_i,
    output logic [31:0] top_o
);

    localparam int PTR_W = $clog2(RAS_DEPTH);

    logic [31:0]      stack [RAS_DEPTH];
    logic [PTR_W-1:0] top_ptr;  // newest entry
    logic [PTR_W-1:0] wr_ptr;   // slot above the top

    always_ff @(posedge clk) begin
        if (push_i) begin
            stack[wr_ptr] <= push_addr_i;
        end
    end

    // grows upward, pointers wrap on overflow
    always_ff @(posedge clk) begin
        if (rst) begin
            top_ptr <= '1;
            wr_ptr  <= '0;
        end else if (push_i) begin
            top_ptr <= wr_ptr;
            wr_ptr  <= wr_ptr + 1'b1;
        end else if (pop_i) begin
            wr_ptr  <= top_ptr;
            top_ptr <= top_ptr - 1'b1;
        end
    end

    assign top_o = stack[top_ptr];

    // a taken call or return masks the other slot of the pair
    assert property (@(posedge clk) disable iff (rst) !(push_i && pop_i))
        else $error("return stack push and pop together");

endmodule

//--- source/bp_target_buffer.sv
`timescale 1ns/1ns

module bp_target_buffer #(
    parameter int BTB_INDEX_W = 7
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [31:0]              rd_pc_i,
    input  logic [31:0]              cur_pc_i,
    input  logic [1:0]               wr_en_i,
    input  logic [BTB_INDEX_W-1:0]   wr_index_i,
    input  logic [bp_pkg::TAG_W-1:0] wr_tag_i,
    input  logic [31:0]              wr_target_i,
    input  bp_pkg::br_type_e         wr_type_i,
    input  logic                     wr_is_branch_i,
    input  logic                     wr_is_uncond_i,
    output logic [1:0]               hit_o,
    output bp_pkg::br_type_e         type_o [2],
    output logic [31:0]              target_o [2],
    output logic [1:0]               is_uncond_o
);

    localparam int DEPTH   = 2 ** BTB_INDEX_W;
    localparam int ENTRY_W = bp_pkg::TAG_W + 32 + 2 + 2;

    logic [31:0]              rd_hash;
    logic [BTB_INDEX_W-1:0]   rd_index;
    logic [ENTRY_W-1:0]       wr_entry;
    logic [bp_pkg::TAG_W-1:0] cur_tag;

    assign rd_hash  = bp_pkg::btb_hash(rd_pc_i);
    assign rd_index = rd_hash[BTB_INDEX_W-1:0];
    assign cur_tag  = bp_pkg::get_tag(cur_pc_i);

    // entry layout {tag, target, type, is_branch, is_uncond}
    assign wr_entry = {wr_tag_i, wr_target_i, wr_type_i, wr_is_branch_i, wr_is_uncond_i};

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic [ENTRY_W-1:0]       mem [DEPTH];
        logic [DEPTH-1:0]         valid_bits;
        logic [ENTRY_W-1:0]       rd_entry;
        logic                     rd_valid;
        logic                     bypass;
        logic [bp_pkg::TAG_W-1:0] rd_tag;

        assign bypass = wr_en_i[b] && (wr_index_i == rd_index);

        always_ff @(posedge clk) begin
            if (wr_en_i[b]) begin
                mem[wr_index_i] <= wr_entry;
            end
            rd_entry <= bypass ? wr_entry : mem[rd_index];  // fresh write wins
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                valid_bits <= '0;
                rd_valid   <= 1'b0;
            end else begin
                if (wr_en_i[b]) begin
                    valid_bits[wr_index_i] <= 1'b1;
                end
                rd_valid <= bypass || valid_bits[rd_index];
            end
        end

        assign rd_tag         = rd_entry[ENTRY_W-1 -: bp_pkg::TAG_W];
        assign target_o[b]    = rd_entry[35:4];
        assign type_o[b]      = bp_pkg::br_type_e'(rd_entry[3:2]);
        assign is_uncond_o[b] = rd_entry[0];

        // tag compares against the pair now on pc_o
        assign hit_o[b] = rd_valid && (rd_tag == cur_tag) && rd_entry[1];
    end

endmodule

//--- source/bp_update_decode.sv
`timescale 1ns/1ns

module bp_update_decode #(
    parameter int BTB_INDEX_W = 7,
    parameter int HISTORY_W   = 5,
    parameter int PHT_PC_W    = 7
) (
    input  logic                          clk,
    input  logic [1:0]                    upd_valid_i,
    input  logic [31:0]                   upd_pc_i [2],
    input  logic [31:0]                   upd_target_i [2],
    input  bp_pkg::br_type_e              upd_type_i [2],
    input  logic [1:0]                    upd_is_branch_i,
    input  logic [1:0]                    upd_taken_i,
    input  logic [HISTORY_W-1:0]          upd_history_i [2],
    input  logic [1:0]                    upd_scnt_i [2],
    input  logic [1:0]                    upd_type_miss_i,
    output logic [1:0]                    wr_en_o,
    output logic [BTB_INDEX_W-1:0]        wr_index_o,
    output logic [bp_pkg::TAG_W-1:0]      wr_tag_o,
    output logic [31:0]                   wr_target_o,
    output bp_pkg::br_type_e              wr_type_o,
    output logic                          wr_is_branch_o,
    output logic                          wr_is_uncond_o,
    output logic [HISTORY_W-1:0]          wr_history_o,
    output logic [HISTORY_W+PHT_PC_W-1:0] wr_pht_index_o,
    output logic [1:0]                    wr_scnt_o
);

    logic        sel;  // slot 1 only when slot 0 is idle
    logic [31:0] sel_pc;
    logic [31:0] sel_hash;
    logic        sel_taken;

    assign sel       = !upd_valid_i[0];
    assign sel_pc    = upd_pc_i[sel];
    assign sel_taken = upd_taken_i[sel];
    assign sel_hash  = bp_pkg::btb_hash(sel_pc);

    // bank follows the slot position inside the pair
    assign wr_en_o = upd_valid_i[sel] ? (sel_pc[2] ? 2'b10 : 2'b01) : 2'b00;

    assign wr_index_o     = sel_hash[BTB_INDEX_W-1:0];
    assign wr_tag_o       = bp_pkg::get_tag(sel_pc);
    assign wr_target_o    = upd_target_i[sel];
    assign wr_type_o      = upd_type_i[sel];
    assign wr_is_branch_o = upd_is_branch_i[sel];
    assign wr_is_uncond_o = upd_is_branch_i[sel] && (upd_type_i[sel] != bp_pkg::BR_NORMAL);
    assign wr_pht_index_o = {upd_history_i[sel], sel_pc[PHT_PC_W+2:3]};  // old history

    // a type miss restarts the pattern from the outcome
    assign wr_history_o = upd_type_miss_i[sel] ? {HISTORY_W{sel_taken}}
                        : {upd_history_i[sel][HISTORY_W-2:0], sel_taken};

    always_comb begin
        case (upd_scnt_i[sel])
            2'b00:   wr_scnt_o = {1'b0, sel_taken};  // strongly not-taken
            2'b01:   wr_scnt_o = {sel_taken, 1'b0};
            2'b10:   wr_scnt_o = {sel_taken, 1'b1};
            default: wr_scnt_o = {1'b1, sel_taken};  // strongly taken
        endcase
    end

    // back end reports word addresses only
    assert property (@(posedge clk) (|upd_valid_i) |-> (sel_pc[1:0] == 2'b00))
        else $error("update pc %h not word aligned", sel_pc);

endmodule

//--- verification/bp_clock_gen.sv
`timescale 1ns/1ns

module bp_clock_gen #(
    parameter int PERIOD = 4
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;  // 50% duty
    end

endmodule

//--- verification/bp_predictor_stimulus.txt
# T name | R ready | F redirect_pc | U slot pc target type taken | I pc mask (random stall)
# C pc mask taken next_pc0 next_pc1, all hex; type 0 cond 1 call 2 return 3 jump
T sequential
R 1
C 1c000000 3 0 1c000004 1c000008
C 1c000008 3 0 1c00000c 1c000010
C 1c000010 3 0 1c000014 1c000018
T redirect_odd
F 1c000104
C 1c000104 2 0 0 1c000108
C 1c000108 3 0 1c00010c 1c000110
T stall
R 0
C 1c000110 3 0 1c000114 1c000118
C 1c000110 3 0 1c000114 1c000118
I 1c000110 3
R 1
C 1c000110 3 0 1c000114 1c000118
C 1c000118 3 0 1c00011c 1c000120
T jump
R 0
U 0 1c000200 1c000340 3 1
F 1c000200
R 1
C 1c000200 1 1 1c000340 0
C 1c000340 3 0 1c000344 1c000348
T conditional
R 0
U 1 1c000404 1c000640 0 1
U 1 1c000404 1c000640 0 1
U 1 1c000404 1c000640 0 1
F 1c000404
C 1c000404 2 0 0 1c000408
U 1 1c000404 1c000640 0 1
C 1c000404 2 2 0 1c000640
R 1
C 1c000404 2 2 0 1c000640
C 1c000640 3 0 1c000644 1c000648
T call_return
R 0
U 0 1c000800 1c000a00 1 1
U 0 1c000a00 0 2 1
F 1c000800
R 1
C 1c000800 1 1 1c000a00 0
C 1c000a00 1 1 1c000804 0
C 1c000804 2 0 0 1c000808

//--- verification/bp_predictor_tb.sv
`timescale 1ns/1ns

module bp_predictor_tb;

    localparam int BTB_INDEX_W = 4;
    localparam int HISTORY_W   = 3;
    localparam int PHT_PC_W    = 3;
    localparam int RAS_DEPTH   = 4;
    localparam int PHT_IDX_W   = HISTORY_W + PHT_PC_W;
    localparam int SWEEP       = 2 ** PHT_IDX_W;
    localparam int PERIOD      = 4;

    logic                 clk;
    logic                 rst;
    logic                 flush;
    logic [31:0]          redirect;
    logic [1:0]           upd_valid;
    logic [31:0]          upd_pc [2];
    logic [31:0]          upd_target [2];
    bp_pkg::br_type_e     upd_type [2];
    logic [1:0]           upd_is_branch;
    logic [1:0]           upd_taken;
    logic [HISTORY_W-1:0] upd_history [2];
    logic [1:0]           upd_scnt [2];
    logic [1:0]           upd_type_miss;
    logic                 fetch_ready;
    logic                 fetch_valid;
    logic [31:0]          pc_o;
    logic [1:0]           mask_o;
    logic [1:0]           taken_o;
    logic [31:0]          target [2];
    logic [31:0]          next_pc [2];
    logic [HISTORY_W-1:0] history [2];
    logic [1:0]           scnt [2];
    logic [1:0]           hit;

    // mirror of the BHT and PHT contents after the init sweep
    logic [HISTORY_W-1:0] bht_model [2][2**BTB_INDEX_W];
    logic [1:0]           pht_model [2][2**PHT_IDX_W];

    // trained BTB entries per bank
    logic                     btb_valid_model [2][2**BTB_INDEX_W];
    logic [bp_pkg::TAG_W-1:0] btb_tag_model [2][2**BTB_INDEX_W];
    logic [31:0]              btb_target_model [2][2**BTB_INDEX_W];
    bp_pkg::br_type_e         btb_type_model [2][2**BTB_INDEX_W];

    string       lines [$];
    string       test_name;
    bit          loaded;
    integer      seed;
    int          tests_run;
    int          test_checks;
    int          test_errors;
    int          total_checks;
    int          total_errors;
    int unsigned timeout_ns;

    bp_clock_gen #(.PERIOD(PERIOD)) clock_gen_i (.clk_o(clk));

    bp_predictor #(
        .BTB_INDEX_W(BTB_INDEX_W),
        .HISTORY_W  (HISTORY_W),
        .PHT_PC_W   (PHT_PC_W),
        .RAS_DEPTH  (RAS_DEPTH)
    ) bp_predictor_i (
        .clk(clk), .rst(rst), .flush_i(flush), .redirect_i(redirect),
        .upd_valid_i(upd_valid), .upd_pc_i(upd_pc), .upd_target_i(upd_target),
        .upd_type_i(upd_type), .upd_is_branch_i(upd_is_branch), .upd_taken_i(upd_taken),
        .upd_history_i(upd_history), .upd_scnt_i(upd_scnt), .upd_type_miss_i(upd_type_miss),
        .fetch_ready_i(fetch_ready), .fetch_valid_o(fetch_valid), .pc_o(pc_o),
        .mask_o(mask_o), .taken_o(taken_o), .target_o(target), .next_pc_o(next_pc),
        .history_o(history), .scnt_o(scnt), .hit_o(hit)
    );

    // BTB and BHT index: pc bits 9 and up xor bits 3 and up
    function automatic int table_index(input logic [31:0] pc);
        logic [31:0] h;
        h = (pc >> 9) ^ (pc >> 3);
        return h[BTB_INDEX_W-1:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        test_checks++;
        total_checks++;
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic close_test();
        if (test_name != "") begin
            $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
            tests_run++;
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    // one corrected branch on one update slot, history and counter from the model
    task automatic apply_update(input int slot, input logic [31:0] pc,
                                input logic [31:0] tgt, input int kind, input logic taken);
        int                   bank;
        int                   idx;
        int                   pidx;
        logic [HISTORY_W-1:0] hist;
        logic [1:0]           cnt;
        bank = pc[2];
        idx  = table_index(pc);
        hist = bht_model[bank][idx];
        pidx = {hist, pc[PHT_PC_W+2:3]};
        cnt  = pht_model[bank][pidx];
        upd_valid           = '0;
        upd_valid[slot]     = 1'b1;
        upd_pc[slot]        = pc;
        upd_target[slot]    = tgt;
        upd_type[slot]      = bp_pkg::br_type_e'(kind[1:0]);
        upd_is_branch[slot] = 1'b1;
        upd_taken[slot]     = taken;
        upd_history[slot]   = hist;
        upd_scnt[slot]      = cnt;
        upd_type_miss       = '0;
        bht_model[bank][idx] = {hist[HISTORY_W-2:0], taken};
        if (taken && cnt != 2'b11) begin
            cnt = cnt + 1'b1;  // step toward taken
        end else if (!taken && cnt != 2'b00) begin
            cnt = cnt - 1'b1;
        end
        pht_model[bank][pidx] = cnt;
        btb_valid_model[bank][idx]  = 1'b1;
        btb_tag_model[bank][idx]    = pc[12 +: bp_pkg::TAG_W];
        btb_target_model[bank][idx] = tgt;
        btb_type_model[bank][idx]   = bp_pkg::br_type_e'(kind[1:0]);
        @(negedge clk);
        upd_valid = '0;
    endtask

    task automatic check_pair(input logic [31:0] pc, input logic [1:0] mask,
                              input logic [1:0] taken, input logic [31:0] next0,
                              input logic [31:0] next1);
        int                   b;
        int                   idx;
        logic [HISTORY_W-1:0] hist;
        logic                 exp_hit;
        while (fetch_valid !== 1'b1) begin
            @(negedge clk);
        end
        check_value("pc_o", pc_o, pc);
        check_value("mask_o", mask_o, mask);
        check_value("taken_o", taken_o, taken);
        if (mask[0]) check_value("next_pc_o[0]", next_pc[0], next0);
        if (mask[1]) check_value("next_pc_o[1]", next_pc[1], next1);
        idx = table_index(pc);
        for (b = 0; b < 2; b++) begin
            hist = bht_model[b][idx];
            check_value($sformatf("history_o[%0d]", b), history[b], hist);
            check_value($sformatf("scnt_o[%0d]", b), scnt[b],
                        pht_model[b][{hist, pc[PHT_PC_W+2:3]}]);
            exp_hit = btb_valid_model[b][idx]
                   && (btb_tag_model[b][idx] == pc[12 +: bp_pkg::TAG_W]);
            check_value($sformatf("hit_o[%0d]", b), hit[b], exp_hit);
            // a return takes its target from the RAS
            if (exp_hit && btb_type_model[b][idx] != bp_pkg::BR_RETURN) begin
                check_value($sformatf("target_o[%0d]", b), target[b],
                            btb_target_model[b][idx]);
            end
        end
        @(negedge clk);
    endtask

    // fetch stalled for a random number of cycles, pair must hold
    task automatic stall_random(input logic [31:0] pc, input logic [1:0] mask);
        int   cycles;
        logic saved;
        cycles = 1 + ($unsigned($random(seed)) % 8);
        saved  = fetch_ready;
        fetch_ready = 1'b0;
        check_value("pc_o", pc_o, pc);
        repeat (cycles) begin
            @(negedge clk);
            check_value("pc_o", pc_o, pc);
            check_value("mask_o", mask_o, mask);
        end
        fetch_ready = saved;
    endtask

    task automatic run_line(input string line);
        string       cmd;
        string       name;
        logic [31:0] a, b, c, d, e;
        int          n;
        n = $sscanf(line, "%s", cmd);
        if (n < 1 || cmd.substr(0, 0) == "#") return;
        if (cmd == "T") begin
            close_test();
            n = $sscanf(line, "%s %s", cmd, name);
            test_name = name;
        end else begin
            n = $sscanf(line, "%s %h %h %h %h %h", cmd, a, b, c, d, e);
            if (cmd == "R") begin
                fetch_ready = a[0];
            end else if (cmd == "F") begin
                flush    = 1'b1;  // one cycle redirect
                redirect = a;
                @(negedge clk);
                flush = 1'b0;
            end else if (cmd == "U") begin
                apply_update(a, b, c, d, e[0]);
            end else if (cmd == "C") begin
                check_pair(a, b[1:0], c[1:0], d, e);
            end else if (cmd == "I") begin
                stall_random(a, b[1:0]);
            end else begin
                $display("unknown stimulus command %s in line: %s", cmd, line);
                test_errors++;
                total_errors++;
            end
        end
    endtask

    initial begin
        wait (loaded);
        timeout_ns = (5 + SWEEP + 20 * lines.size()) * PERIOD;
        #(timeout_ns);
        $display("timeout: the stimulus did not finish in %0d ns", timeout_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int    fd;
        string line;
        rst           = 1'b1;
        flush         = 1'b0;
        redirect      = '0;
        upd_valid     = '0;
        upd_pc        = '{default: '0};
        upd_target    = '{default: '0};
        upd_type      = '{default: bp_pkg::BR_NORMAL};
        upd_is_branch = '0;
        upd_taken     = '0;
        upd_history   = '{default: '0};
        upd_scnt      = '{default: '0};
        upd_type_miss = '0;
        fetch_ready   = 1'b0;
        seed          = 29200;
        test_name     = "";
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < 2**BTB_INDEX_W; i++) begin
                bht_model[b][i]       = '0;
                btb_valid_model[b][i] = 1'b0;
            end
            for (int i = 0; i < 2**PHT_IDX_W; i++) begin
                pht_model[b][i] = 2'b01;  // weakly not-taken
            end
        end
        fd = $fopen("verification/bp_predictor_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            while ($fgets(line, fd)) begin
                lines.push_back(line);
            end
            $fclose(fd);
            loaded = 1'b1;
            repeat (5) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            check_value("fetch_valid_o", fetch_valid, 1'b0);  // sweep still running
            foreach (lines[i]) run_line(lines[i]);
            close_test();
            $display("%0d tests, %0d checks, %0d errors", tests_run, total_checks, total_errors);
            if (total_errors == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

endmodule
